// ==== hdl/chess_pkg.sv ====
// ====================
// Chess board encoding
// Piece codes, squares and board layout
// ====================
`default_nettype none

package chess_pkg;

   localparam int NUM_SQUARES = 64;                   // Full 8x8 board
   localparam int COUNT_WIDTH = $clog2(NUM_SQUARES + 1); // Holds 0..64

   // Low three bits of a square
   typedef enum logic [2:0]
   {
      PIECE_EMPTY  = 3'd0,
      PIECE_PAWN   = 3'd1,
      PIECE_KNIGHT = 3'd2,
      PIECE_BISHOP = 3'd3,
      PIECE_ROOK   = 3'd4,
      PIECE_QUEEN  = 3'd5,
      PIECE_KING   = 3'd6
   } piece_type_t;

   typedef struct packed
   {
      logic        black; // Bit 3, set for black
      piece_type_t kind;  // Bits 2..0
   } piece_t;

   typedef piece_t [NUM_SQUARES-1:0] board_t; // Square k at bits 4k+3..4k
   typedef logic [COUNT_WIDTH-1:0] count_t;   // Square population count

endpackage

`default_nettype wire

// ==== hdl/eval_pkg.sv ====
// ====================
// Evaluation constants
// Score widths, piece values, blend setup
// ====================
`default_nettype none

package eval_pkg;

   localparam int EVAL_WIDTH = 16;
   typedef logic signed [EVAL_WIDTH-1:0] score_t; // Final centipawn score

   localparam int CALC_WIDTH = 40;
   typedef logic signed [CALC_WIDTH-1:0] calc_t;  // Sums and wide products

   localparam int PHASE_MAX = 62;                 // Full midgame weight
   typedef logic [5:0] phase_t;

   localparam int SQUARES_PER_CYCLE = 8;          // One rank per clock
   localparam int SCAN_CYCLES = 8;

   localparam int RECIP_SHIFT = 20;
   localparam int RECIP_SCALE = 16912;            // 2^20 / 62, truncated

   localparam int BLEND_LATENCY = 5;              // Blend pipeline depth

   // Indexed by piece type code, empty/king/unused give nothing
   localparam int MG_VALUE [0:7] = '{0, 82, 337, 365, 477, 1025, 0, 0};
   localparam int EG_VALUE [0:7] = '{0, 94, 281, 297, 512, 936, 0, 0};

endpackage

`default_nettype wire

// ==== hdl/score_if.sv ====
// ====================
// Scan result bus to blend stage
// ====================
`timescale 1ns/10ps
`default_nettype none

interface score_if;
   import chess_pkg::*;
   import eval_pkg::*;

   logic   valid;       // Single cycle pulse
   calc_t  mg;          // Midgame material, white minus black
   calc_t  eg;          // Endgame material
   count_t phase_count; // Non-pawn pieces, kings included

   modport source (output valid, mg, eg, phase_count);
   modport sink   (input  valid, mg, eg, phase_count);

endinterface

`default_nettype wire

// ==== hdl/board_sequencer.sv ====
// ====================
// Evaluation sequencer
// Start edge, board latch, result hold
// ====================
`timescale 1ns/10ps
`default_nettype none

module board_sequencer
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              board_valid,
   input  wire chess_pkg::board_t board_in,
   input  wire logic              blend_valid,
   input  wire eval_pkg::score_t  blend_eval,
   input  wire logic              clear_eval,
   output logic                   scan_start,
   output chess_pkg::board_t      board,
   output eval_pkg::score_t       eval,
   output logic                   eval_valid
);
   import chess_pkg::*;
   import eval_pkg::*;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_WAIT_STATE,
      ST_WAIT_RESULT,
      ST_HOLD
   } state_t;

   state_t state;
   logic   board_valid_r; // Previous board_valid for edge detect
   logic   start_edge;
   board_t board_pre;     // Idle capture ahead of timing flop

   assign start_edge = board_valid && !board_valid_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         board_valid_r <= 1'b0;
         scan_start    <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         scan_start    <= 1'b0; // Pulse by default
         case (state)
            ST_IDLE:
               if (start_edge)
                  state <= ST_WAIT_STATE;
            ST_WAIT_STATE:
            begin
               scan_start <= 1'b1;  // Board flop settled by now
               state      <= ST_WAIT_RESULT;
            end
            ST_WAIT_RESULT:
               if (blend_valid)
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_HOLD;
               end
            ST_HOLD:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= ST_IDLE;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE)
         board_pre <= board_in; // Track input until start
      board <= board_pre;       // Extra flop for timing
      if (state == ST_WAIT_RESULT && blend_valid)
         eval <= blend_eval;
   end

   // Result drops only after a clear request
   a_valid_fall: assert property (@(posedge clk) disable iff (reset)
      $fell(eval_valid) |-> $past(clear_eval));

   // Held score stays put
   a_eval_hold: assert property (@(posedge clk) disable iff (reset)
      eval_valid && $past(eval_valid) |-> eval == $past(eval));

endmodule

`default_nettype wire

// ==== hdl/material_scan.sv ====
// ====================
// Material scanner
// Eight squares per clock, sums and phase
// ====================
`timescale 1ns/10ps
`default_nettype none

module material_scan
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              scan_start,
   input  wire chess_pkg::board_t board,
   score_if.source                score
);
   import chess_pkg::*;
   import eval_pkg::*;

   localparam int GROUP_WIDTH = $clog2(SCAN_CYCLES);

   logic [GROUP_WIDTH-1:0] grp;  // Square group now in view
   logic                   busy; // Groups 1..7 still to add
   calc_t                  grp_mg;
   calc_t                  grp_eg;
   logic [3:0]             grp_count;

   // Material and phase for the current group
   always_comb
   begin
      piece_t sq;
      calc_t  val_mg;
      calc_t  val_eg;

      grp_mg    = '0;
      grp_eg    = '0;
      grp_count = '0;
      for (int i = 0; i < SQUARES_PER_CYCLE; i++)
      begin
         sq     = board[grp * SQUARES_PER_CYCLE + i];
         val_mg = calc_t'(MG_VALUE[sq.kind]);
         val_eg = calc_t'(EG_VALUE[sq.kind]);
         grp_mg = sq.black ? grp_mg - val_mg : grp_mg + val_mg; // Black subtracts
         grp_eg = sq.black ? grp_eg - val_eg : grp_eg + val_eg;
         if (sq.kind != PIECE_EMPTY && sq.kind != PIECE_PAWN)
            grp_count = grp_count + 4'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         grp         <= '0;
         busy        <= 1'b0;
         score.valid <= 1'b0;
      end
      else
      begin
         score.valid <= 1'b0;
         if (scan_start)
         begin
            grp  <= GROUP_WIDTH'(1); // Group 0 taken this cycle
            busy <= 1'b1;
         end
         else if (busy)
         begin
            grp <= grp + 1'b1;       // Wraps back to 0
            if (grp == GROUP_WIDTH'(SCAN_CYCLES - 1))
            begin
               busy        <= 1'b0;
               score.valid <= 1'b1;
            end
         end
      end
   end

   // Accumulators, first group loads directly
   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         score.mg          <= grp_mg;
         score.eg          <= grp_eg;
         score.phase_count <= count_t'(grp_count);
      end
      else if (busy)
      begin
         score.mg          <= score.mg + grp_mg;
         score.eg          <= score.eg + grp_eg;
         score.phase_count <= score.phase_count + count_t'(grp_count);
      end
   end

   // Sequencer waits for the result before a new start
   a_no_restart: assert property (@(posedge clk) disable iff (reset)
      busy |-> !scan_start);

endmodule

`default_nettype wire

// ==== hdl/taper_blend.sv ====
// ====================
// Tapered blend pipeline
// Mixes midgame and endgame by phase
// ====================
`timescale 1ns/10ps
`default_nettype none

module taper_blend
(
   input  wire logic        clk,
   input  wire logic        reset,
   score_if.sink            score,
   output logic             blend_valid,
   output eval_pkg::score_t blend_eval
);
   import eval_pkg::*;

   logic [BLEND_LATENCY-1:0] vld_pipe; // One bit per stage
   phase_t                   s1_phase;
   calc_t                    s1_mg;
   calc_t                    s1_eg;
   calc_t                    s2_mg;
   calc_t                    s2_eg;
   calc_t                    s3_sum;
   calc_t                    s4_scaled;
   calc_t                    quotient;

   always_ff @(posedge clk)
   begin
      if (reset)
         vld_pipe <= '0;
      else
         vld_pipe <= {vld_pipe[BLEND_LATENCY-2:0], score.valid};
   end

   assign blend_valid = vld_pipe[BLEND_LATENCY-1];

   // Signed divide truncates toward zero
   assign quotient = s4_scaled / (calc_t'(1) <<< RECIP_SHIFT);

   always_ff @(posedge clk)
   begin
      // Stage 1, clamp phase
      s1_phase <= (score.phase_count > PHASE_MAX) ? phase_t'(PHASE_MAX)
                                                  : phase_t'(score.phase_count);
      s1_mg    <= score.mg;
      s1_eg    <= score.eg;
      // Stage 2, weight by phase
      s2_mg    <= s1_mg * calc_t'(s1_phase);
      s2_eg    <= s1_eg * calc_t'(PHASE_MAX - s1_phase);
      // Stage 3
      s3_sum   <= s2_mg + s2_eg;
      // Stage 4, reciprocal of 62
      s4_scaled <= s3_sum * RECIP_SCALE;
      // Stage 5, back to score width
      blend_eval <= score_t'(quotient);
   end

   // Fixed latency, no stalls
   a_latency: assert property (@(posedge clk) disable iff (reset)
      blend_valid == $past(score.valid, BLEND_LATENCY));

endmodule

`default_nettype wire

// ==== hdl/eval_top.sv ====
// ====================
// Static evaluator top
// ====================
`timescale 1ns/10ps
`default_nettype none

module eval_top
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              board_valid,
   input  wire chess_pkg::board_t board_in,
   input  wire logic              clear_eval,
   output wire eval_pkg::score_t  eval,
   output wire logic              eval_valid
);
   import chess_pkg::*;
   import eval_pkg::*;

   logic   scan_start;
   board_t board;       // Latched copy under scan
   logic   blend_valid;
   score_t blend_eval;

   score_if score_bus (); // Scan to blend

   board_sequencer seq_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .blend_valid (blend_valid),
      .blend_eval  (blend_eval),
      .clear_eval  (clear_eval),
      .scan_start  (scan_start),
      .board       (board),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   material_scan scan_i
   (
      .clk        (clk),
      .reset      (reset),
      .scan_start (scan_start),
      .board      (board),
      .score      (score_bus.source)
   );

   taper_blend blend_i
   (
      .clk         (clk),
      .reset       (reset),
      .score       (score_bus.sink),
      .blend_valid (blend_valid),
      .blend_eval  (blend_eval)
   );

endmodule

`default_nettype wire

// ==== dv/eval_checker.sv ====
// ====================
// Evaluator result checker
// Value, latency and hold checks
// ====================
`timescale 1ns/10ps
`default_nettype none

module eval_checker
#(
   parameter int CLK_PERIOD = 100
)
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              board_valid,
   input  wire logic              clear_eval,
   input  wire eval_pkg::score_t  eval,
   input  wire logic              eval_valid,
   input  wire logic              exp_load,   // One strobe per launched board
   input  wire eval_pkg::score_t  exp_eval,
   input  wire logic [63:0]       exp_start,  // Time of the start edge
   output int                     error_count,
   output int                     result_count
);
   import eval_pkg::*;

   localparam int LATENCY = 16; // Start edge to eval_valid high

   int          errors = 0;
   int          results = 0;
   logic        pending;        // Board in flight, result not yet seen
   logic        started;        // Some start edge seen since reset
   score_t      want;
   logic [63:0] start_t;
   logic        prev_valid;
   logic        prev_clear;
   logic        prev_board_valid;
   score_t      prev_eval;

   assign error_count  = errors;
   assign result_count = results;

   always @(posedge clk)
   begin
      if (reset)
      begin
         pending          = 1'b0;
         started          = 1'b0;
         prev_valid       = 1'b0;
         prev_clear       = 1'b0;
         prev_board_valid = 1'b0;
      end
      else
      begin
         // Nothing may show up before the first board
         if (!started && eval_valid !== 1'b0)
         begin
            $display("Error at %0t: eval_valid is %b before the first start edge",
                     $time, eval_valid);
            errors++;
         end
         if (board_valid && !prev_board_valid)
            started = 1'b1;
         if (exp_load)
         begin
            pending = 1'b1;
            want    = exp_eval;
            start_t = exp_start;
         end
         if (eval_valid && !prev_valid)
         begin
            results++;
            if (!pending)
            begin
               $display("Error at %0t: eval_valid rose with no board in flight", $time);
               errors++;
            end
            else
            begin
               if ($time - start_t != LATENCY * CLK_PERIOD)
               begin
                  $display("Error at %0t: eval_valid after %0d cycles, expected %0d",
                           $time, ($time - start_t) / CLK_PERIOD, LATENCY);
                  errors++;
               end
               if (eval !== want)
               begin
                  $display("Error at %0t: eval %0d, expected %0d", $time, eval, want);
                  errors++;
               end
            end
            pending = 1'b0;
         end
         if (eval_valid && prev_valid && eval !== prev_eval)
         begin
            $display("Error at %0t: eval moved from %0d to %0d during hold",
                     $time, prev_eval, eval);
            errors++;
         end
         if (prev_valid && !eval_valid && !prev_clear)
         begin
            $display("Error at %0t: eval_valid fell without clear_eval", $time);
            errors++;
         end
         if (prev_valid && eval_valid && prev_clear)
         begin
            $display("Error at %0t: eval_valid still high after clear_eval", $time);
            errors++;
         end
         prev_valid       = eval_valid; // Values from just before this edge
         prev_clear       = clear_eval;
         prev_board_valid = board_valid;
         prev_eval        = eval;
      end
   end

endmodule

`default_nettype wire

// ==== dv/eval_tb.sv ====
// ====================
// Evaluator testbench
// Stimulus, reference model, closing report
// ====================
`timescale 1ns/10ps
`default_nettype none

module eval_tb;
   import chess_pkg::*;
   import eval_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_RANDOM = 20;
   localparam int WAIT_LIMIT = 40;    // Cycles allowed for a result

   logic        clk;
   logic        reset;
   logic        board_valid;
   board_t      board_in;
   logic        clear_eval;
   score_t      eval;
   logic        eval_valid;
   logic        exp_load;
   score_t      exp_eval;
   logic [63:0] exp_start;
   int          error_count;
   int          result_count;
   int          launched = 0;
   int          timeouts = 0;
   int          seed;

   eval_top dut_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   eval_checker #(.CLK_PERIOD(CLK_PERIOD)) chk_i
   (
      .clk          (clk),
      .reset        (reset),
      .board_valid  (board_valid),
      .clear_eval   (clear_eval),
      .eval         (eval),
      .eval_valid   (eval_valid),
      .exp_load     (exp_load),
      .exp_eval     (exp_eval),
      .exp_start    (exp_start),
      .error_count  (error_count),
      .result_count (result_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Tapered material score straight from the piece tables
   function automatic score_t ref_eval(input board_t b);
      int     mg;
      int     eg;
      int     phase;
      int     sign;
      longint blend;
      mg    = 0;
      eg    = 0;
      phase = 0;
      for (int k = 0; k < NUM_SQUARES; k++)
      begin
         sign = b[k].black ? -1 : 1;  // Black counts against white
         mg  += sign * MG_VALUE[b[k].kind];
         eg  += sign * EG_VALUE[b[k].kind];
         if (b[k].kind != PIECE_EMPTY && b[k].kind != PIECE_PAWN)
            phase++;                  // Kings count too
      end
      if (phase > 62)
         phase = 62;
      blend = (longint'(mg) * phase + longint'(eg) * (62 - phase)) * 16912;
      return score_t'(blend / (longint'(1) << 20)); // Truncates toward zero
   endfunction

   function automatic board_t start_board();
      board_t      b;
      piece_type_t back [0:7];
      back = '{PIECE_ROOK, PIECE_KNIGHT, PIECE_BISHOP, PIECE_QUEEN,
               PIECE_KING, PIECE_BISHOP, PIECE_KNIGHT, PIECE_ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f]      = '{1'b0, back[f]};
         b[8 + f]  = '{1'b0, PIECE_PAWN};
         b[48 + f] = '{1'b1, PIECE_PAWN};
         b[56 + f] = '{1'b1, back[f]};
      end
      return b;
   endfunction

   function automatic board_t random_board();
      board_t b;
      b = '0;
      for (int k = 0; k < NUM_SQUARES; k++)
      begin
         if ($urandom_range(0, 1) != 0) // About half the squares occupied
         begin
            b[k].black = 1'($urandom_range(0, 1));
            b[k].kind  = piece_type_t'(3'($urandom_range(1, 6)));
         end
      end
      return b;
   endfunction

   // 64 non-pawn pieces, phase must clamp
   function automatic board_t queen_board();
      board_t b;
      for (int k = 0; k < NUM_SQUARES; k++)
         b[k] = '{(k >= 40), PIECE_QUEEN};
      b[0]  = '{1'b0, PIECE_KING};
      b[63] = '{1'b1, PIECE_KING};
      return b;
   endfunction

   // One board from start edge through hold and clear
   task automatic run_eval(input board_t b, output bit ok);
      int waited;
      int hold_len;
      @(posedge clk);
      board_in    <= b;
      board_valid <= 1'b1;
      @(posedge clk);                  // Start edge sampled here
      exp_eval  <= ref_eval(b);
      exp_start <= $time;
      exp_load  <= 1'b1;
      launched++;
      @(posedge clk);
      exp_load    <= 1'b0;
      board_valid <= 1'b0;
      waited = 0;
      while (!eval_valid && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      ok = eval_valid;
      if (!ok)
      begin
         $display("Timeout: no result %0d cycles into board %0d", WAIT_LIMIT, launched);
         timeouts++;
      end
      else
      begin
         hold_len = $urandom_range(4, 12);
         for (int i = 0; i < hold_len; i++)
         begin
            @(posedge clk);
            if (i == 1)
            begin
               board_valid <= 1'b1;    // Start edge during hold, ignored
               board_in    <= random_board();
            end
            if (i == 2)
               board_valid <= 1'b0;
         end
         clear_eval <= 1'b1;
         @(posedge clk);
         clear_eval <= 1'b0;
         waited = 0;
         while (eval_valid && waited < 4)
         begin
            @(posedge clk);
            waited++;
         end
         if (eval_valid)
         begin
            $display("Timeout: eval_valid stayed high after clear_eval");
            timeouts++;
            ok = 1'b0;
         end
      end
   endtask

   initial
   begin : main_seq
      bit ok;
      seed        = $urandom(21945);
      reset       = 1'b1;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      exp_load    = 1'b0;
      exp_eval    = '0;
      exp_start   = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (20) @(posedge clk);     // Idle, no result may show up
      run_eval(start_board(), ok);
      for (int n = 0; n < NUM_RANDOM && ok; n++)
         run_eval(random_board(), ok);
      if (ok)
         run_eval(queen_board(), ok);
      repeat (4) @(posedge clk);
      $display("Summary: %0d boards, %0d results, %0d errors, %0d timeouts",
               launched, result_count, error_count, timeouts);
      if (error_count == 0 && timeouts == 0 && result_count == launched)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/chess_pkg.sv
hdl/eval_pkg.sv
hdl/score_if.sv
hdl/board_sequencer.sv
hdl/material_scan.sv
hdl/taper_blend.sv
hdl/eval_top.sv
dv/eval_checker.sv
dv/eval_tb.sv

// ==== Makefile ====
# Verilator build and run for the chess evaluator testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module eval_tb \
		-Mdir obj_dir -o eval_sim

run: compile
	./obj_dir/eval_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
